// ==== sources.f ====
+incdir+tb
rtl/rs_pkg.sv
rtl/reservation_station.sv
rtl/issue_unit.sv
rtl/alu_unit.sv
rtl/rs_top.sv
tb/rs_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rs_tb -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vrs_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Verification passed"; then
    exit 0
fi
echo "simulation did not report success"
exit 1

// ==== tb/rs_tb_stim.svh ====
task automatic build_table();
    // name, function, destination tag, kind and value of source one, kind and value of
    // source two, idle cycles before the load
    // a SRC_TAG source names the destination tag of an earlier row

    // independent rows into an empty station, one per ALU function
    add_row("indep",   ALU_ADD, 5'd1,  SRC_VAL, 32'd100,        SRC_VAL, 32'd23,         4);
    add_row("indep",   ALU_SUB, 5'd2,  SRC_VAL, 32'd5,          SRC_VAL, 32'd9,          3);
    add_row("indep",   ALU_AND, 5'd3,  SRC_VAL, 32'hffff_00ff,  SRC_VAL, 32'h0f0f_0f0f,  3);
    add_row("indep",   ALU_OR,  5'd4,  SRC_VAL, 32'h0000_f0f0,  SRC_VAL, 32'h1234_0000,  3);
    add_row("indep",   ALU_XOR, 5'd5,  SRC_VAL, 32'ha5a5_a5a5,  SRC_VAL, 32'hffff_0000,  3);
    add_row("indep",   ALU_SLL, 5'd6,  SRC_VAL, 32'd1,          SRC_VAL, 32'd33,         3);
    add_row("indep",   ALU_SRL, 5'd7,  SRC_VAL, 32'h8000_0000,  SRC_VAL, 32'd4,          3);
    add_row("indep",   ALU_SLT, 5'd8,  SRC_VAL, 32'hffff_fffd,  SRC_VAL, 32'd2,          3);

    // two idle cycles put each dependent load in the cycle of its source's broadcast
    add_row("forward", ALU_ADD, 5'd9,  SRC_VAL, 32'd7,          SRC_VAL, 32'd8,          6);
    add_row("forward", ALU_SUB, 5'd10, SRC_TAG, 32'd9,          SRC_VAL, 32'd5,          2);
    add_row("forward", ALU_SUB, 5'd11, SRC_VAL, 32'd100,        SRC_TAG, 32'd10,         2);

    // all ready and back to back
    add_row("order",   ALU_XOR, 5'd12, SRC_VAL, 32'd1,          SRC_VAL, 32'd2,          6);
    add_row("order",   ALU_OR,  5'd13, SRC_VAL, 32'd4,          SRC_VAL, 32'd8,          0);
    add_row("order",   ALU_AND, 5'd14, SRC_VAL, 32'hff,         SRC_VAL, 32'h0f,         0);

    // seven link chain, long enough for its waiters to fill all eight entries
    add_row("chain",   ALU_ADD, 5'd15, SRC_VAL, 32'd1,          SRC_VAL, 32'd2,          6);
    add_row("chain",   ALU_ADD, 5'd16, SRC_TAG, 32'd15,         SRC_VAL, 32'd10,         0);
    add_row("chain",   ALU_SUB, 5'd17, SRC_TAG, 32'd16,         SRC_VAL, 32'd3,          0);
    add_row("chain",   ALU_SLL, 5'd18, SRC_TAG, 32'd17,         SRC_VAL, 32'd2,          0);
    add_row("chain",   ALU_XOR, 5'd19, SRC_TAG, 32'd18,         SRC_VAL, 32'd55,         0);
    add_row("chain",   ALU_OR,  5'd20, SRC_TAG, 32'd19,         SRC_VAL, 32'd100,        0);
    add_row("chain",   ALU_ADD, 5'd21, SRC_TAG, 32'd20,         SRC_TAG, 32'd20,         0);

    // nine waiters on the chain end, the ninth has to wait for a credit
    add_row("burst",   ALU_ADD, 5'd22, SRC_TAG, 32'd21,         SRC_TAG, 32'd21,         0);
    add_row("burst",   ALU_SUB, 5'd23, SRC_VAL, 32'd1000,       SRC_TAG, 32'd21,         0);
    add_row("burst",   ALU_AND, 5'd24, SRC_TAG, 32'd21,         SRC_VAL, 32'hff,         0);
    add_row("burst",   ALU_OR,  5'd25, SRC_TAG, 32'd21,         SRC_VAL, 32'h8000_0000,  0);
    add_row("burst",   ALU_XOR, 5'd26, SRC_TAG, 32'd21,         SRC_VAL, 32'hffff_ffff,  0);
    add_row("burst",   ALU_SLL, 5'd27, SRC_TAG, 32'd21,         SRC_VAL, 32'd4,          0);
    add_row("burst",   ALU_SRL, 5'd28, SRC_TAG, 32'd21,         SRC_VAL, 32'd1,          0);
    add_row("burst",   ALU_SLT, 5'd29, SRC_TAG, 32'd21,         SRC_VAL, 32'h7fff_ffff,  0);
    add_row("burst",   ALU_SLT, 5'd30, SRC_VAL, 32'hffff_ffff,  SRC_TAG, 32'd21,         0);
endtask

// ==== tb/rs_tb.sv ====
`timescale 1ns/1ns

module rs_tb;
    import rs_pkg::*;

    localparam int MAX_ROWS = 32;    // every row owns one destination tag
    localparam bit SRC_VAL  = 1'b0;  // source column is a literal operand
    localparam bit SRC_TAG  = 1'b1;  // source column is the tag of an earlier row

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   load;
    alu_func_t              func;
    logic [ROB_TAG_LEN-1:0] t1;
    logic [ROB_TAG_LEN-1:0] t2;
    logic [ROB_TAG_LEN-1:0] dst;
    logic                   ready1;
    logic                   ready2;
    logic [XLEN-1:0]        v1;
    logic [XLEN-1:0]        v2;
    logic                   credit_return;
    logic                   result_valid;
    logic [ROB_TAG_LEN-1:0] result_tag;
    logic [XLEN-1:0]        result_value;

    string                  row_name  [MAX_ROWS];
    alu_func_t              row_func  [MAX_ROWS];
    logic [ROB_TAG_LEN-1:0] row_dst   [MAX_ROWS];
    bit                     row_kind1 [MAX_ROWS];
    bit                     row_kind2 [MAX_ROWS];
    logic [XLEN-1:0]        row_src1  [MAX_ROWS];
    logic [XLEN-1:0]        row_src2  [MAX_ROWS];
    int                     row_gap   [MAX_ROWS];
    int                     num_rows = 0;

    // bookkeeping indexed by destination tag
    logic [XLEN-1:0]        exp_val    [MAX_ROWS];  // result from the reference model
    string                  tag_name   [MAX_ROWS];
    bit                     loaded     [MAX_ROWS];
    bit                     done       [MAX_ROWS];  // broadcast seen in an earlier cycle
    bit                     lat_check  [MAX_ROWS];  // loaded ready into an empty station
    int                     seen_count [MAX_ROWS];
    int                     load_cycle [MAX_ROWS];
    logic [ROB_TAG_LEN-1:0] order_q [$];            // every loaded row, oldest first

    int                     cycle = 0;
    int                     limit;
    int                     spent = 0;     // one credit spent per load
    int                     returned = 0;  // credit_return pulses
    int                     bcast_count = 0;
    int                     checks = 0;
    int                     errors = 0;
    int                     idle;
    int                     extra;
    logic [31:0]            lfsr = 32'hfb95;
    logic [ROB_TAG_LEN-1:0] tag;

    `include "rs_tb_stim.svh"

    rs_top i_rs_top (
        .clk           (clk),
        .reset         (reset),
        .load          (load),
        .func          (func),
        .t1            (t1),
        .t2            (t2),
        .dst           (dst),
        .ready1        (ready1),
        .ready2        (ready2),
        .v1            (v1),
        .v2            (v2),
        .credit_return (credit_return),
        .result_valid  (result_valid),
        .result_tag    (result_tag),
        .result_value  (result_value)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois form with taps 32 22 2 1
    endfunction

    // shifts take the low five bits of b and SLT compares signed
    function automatic logic [XLEN-1:0] model_alu(input alu_func_t f, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic int credits();
        return NUM_ENTRIES - spent + returned;  // what the dispatcher may still send
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic add_row(input string name, input alu_func_t f,
                           input logic [ROB_TAG_LEN-1:0] d, input bit k1,
                           input logic [XLEN-1:0] s1, input bit k2,
                           input logic [XLEN-1:0] s2, input int gap);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = (k1 == SRC_TAG) ? exp_val[s1[ROB_TAG_LEN-1:0]] : s1;  // producer's result
        b = (k2 == SRC_TAG) ? exp_val[s2[ROB_TAG_LEN-1:0]] : s2;
        row_name[num_rows]  = name;
        row_func[num_rows]  = f;
        row_dst[num_rows]   = d;
        row_kind1[num_rows] = k1;
        row_kind2[num_rows] = k2;
        row_src1[num_rows]  = s1;
        row_src2[num_rows]  = s2;
        row_gap[num_rows]   = gap;
        exp_val[d]  = model_alu(f, a, b);
        tag_name[d] = name;
        num_rows++;
    endtask

    // two LFSR bits give 0 to 3 extra idle cycles
    task automatic random_idle(output int n);
        n = 0;
        for (int i = 0; i < 2; i++) begin
            n = (n << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // the dispatcher reads the register file once the producer has broadcast
    task automatic pick_source(input bit kind, input logic [XLEN-1:0] src,
                               output logic [ROB_TAG_LEN-1:0] src_tag, output logic src_ready,
                               output logic [XLEN-1:0] src_value);
        src_tag = src[ROB_TAG_LEN-1:0];
        if (kind == SRC_VAL) begin
            src_tag   = '0;
            src_ready = 1'b1;
            src_value = src;
        end else if (done[src_tag]) begin
            src_ready = 1'b1;
            src_value = exp_val[src_tag];
        end else begin
            src_ready = 1'b0;
            src_value = 32'hdead_beef;  // only a broadcast may fill this operand
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > limit) begin
            $display("timeout: %0d of %0d results broadcast after %0d cycles",
                     bcast_count, num_rows, cycle);
            $display("Verification failed");
            $finish;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (spent == 0) begin
                check_value("idle after reset result_valid", '0, XLEN'(result_valid));
                check_value("idle after reset credit_return", '0, XLEN'(credit_return));
            end
            if (credit_return) begin
                returned = returned + 1;
            end
            if (result_valid) begin
                tag = result_tag;
                check_value("broadcast tag was loaded", 32'd1, XLEN'(loaded[tag]));
                check_value(tag_name[tag], exp_val[tag], result_value);
                if (seen_count[tag] == 0 && order_q.size() > 0) begin
                    check_value("load order", XLEN'(order_q.pop_front()), XLEN'(tag));
                end
                seen_count[tag]++;
                bcast_count++;
                if (lat_check[tag]) begin
                    check_value("latency from load", 32'd3, cycle - load_cycle[tag]);
                end
                done[tag] = 1'b1;
            end
        end
    end

    initial begin
        reset  = 1'b1;
        load   = 1'b0;
        func   = ALU_ADD;
        t1     = '0;
        t2     = '0;
        dst    = '0;
        ready1 = 1'b0;
        ready2 = 1'b0;
        v1     = '0;
        v2     = '0;
        build_table();
        limit = 20 * num_rows + 200;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int r = 0; r < num_rows; r++) begin
            idle = row_gap[r];
            // jitter goes only before independent rows so the timed rows keep their spacing
            if (idle > 0 && row_kind1[r] == SRC_VAL && row_kind2[r] == SRC_VAL) begin
                random_idle(extra);
                idle = idle + extra;
            end
            repeat (idle) begin
                load = 1'b0;
                @(posedge clk);
                #2;
            end
            while (credits() == 0) begin  // the station is full so the row waits
                load = 1'b0;
                @(posedge clk);
                #2;
            end
            func = row_func[r];
            dst  = row_dst[r];
            pick_source(row_kind1[r], row_src1[r], t1, ready1, v1);
            pick_source(row_kind2[r], row_src2[r], t2, ready2, v2);
            lat_check[dst] = ready1 && ready2 && (credits() == NUM_ENTRIES);
            // each dependent row waits on the newest result, so the table completes in load
            // order and the burst waiters that wake together must leave oldest first
            order_q.push_back(dst);
            loaded[dst]     = 1'b1;
            load_cycle[dst] = cycle;
            spent = spent + 1;
            load  = 1'b1;
            @(posedge clk);
            #2;
        end
        load = 1'b0;

        while (bcast_count < num_rows) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);  // room for a stray second broadcast
        check_value("credits returned", XLEN'(spent), XLEN'(returned));
        for (int r = 0; r < num_rows; r++) begin
            check_value({row_name[r], " broadcast count"}, 32'd1, seen_count[row_dst[r]]);
        end
        check_value("rows left unissued", '0, XLEN'(order_q.size()));

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== rtl/rs_top.sv ====
`timescale 1ns/1ns

module rs_top (
    input  logic                           clk,
    input  logic                           reset,
    // renamed instruction from the dispatcher, valid with load
    input  logic                           load,
    input  rs_pkg::alu_func_t              func,
    input  logic [rs_pkg::ROB_TAG_LEN-1:0] t1,
    input  logic [rs_pkg::ROB_TAG_LEN-1:0] t2,
    input  logic [rs_pkg::ROB_TAG_LEN-1:0] dst,
    input  logic                           ready1,
    input  logic                           ready2,
    input  logic [rs_pkg::XLEN-1:0]        v1,
    input  logic [rs_pkg::XLEN-1:0]        v2,
    output logic                           credit_return,  // one credit back to the dispatcher
    // result broadcast, always accepted downstream
    output logic                           result_valid,
    output logic [rs_pkg::ROB_TAG_LEN-1:0] result_tag,
    output logic [rs_pkg::XLEN-1:0]        result_value
);
    import rs_pkg::*;

    logic                   insn_ready;
    logic                   issue;
    logic [ROB_TAG_LEN-1:0] dst_tag;
    logic                   start;
    alu_func_t              func_out;
    logic [XLEN-1:0]        v1_out;
    logic [XLEN-1:0]        v2_out;
    logic                   wakeup;      // the broadcast also wakes the station
    logic [ROB_TAG_LEN-1:0] wakeup_tag;
    logic [XLEN-1:0]        result;

    reservation_station i_reservation_station (
        .clk           (clk),
        .reset         (reset),
        .load          (load),
        .func          (func),
        .t1            (t1),
        .t2            (t2),
        .dst           (dst),
        .ready1        (ready1),
        .ready2        (ready2),
        .v1            (v1),
        .v2            (v2),
        .issue         (issue),
        .wakeup        (wakeup),
        .wakeup_tag    (wakeup_tag),
        .wakeup_value  (result),
        .insn_ready    (insn_ready),
        .credit_return (credit_return),
        .dst_tag       (dst_tag),
        .start         (start),
        .func_out      (func_out),
        .v1_out        (v1_out),
        .v2_out        (v2_out)
    );

    issue_unit i_issue_unit (
        .clk        (clk),
        .reset      (reset),
        .insn_ready (insn_ready),
        .dst_tag    (dst_tag),
        .issue      (issue),
        .wakeup     (wakeup),
        .wakeup_tag (wakeup_tag)
    );

    alu_unit i_alu_unit (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .func_out (func_out),
        .v1_out   (v1_out),
        .v2_out   (v2_out),
        .result   (result)
    );

    assign result_valid = wakeup;
    assign result_tag   = wakeup_tag;
    assign result_value = result;  // tag and value line up two cycles after issue

endmodule

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ns

module alu_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,     // operands below are valid this cycle
    input  rs_pkg::alu_func_t       func_out,
    input  logic [rs_pkg::XLEN-1:0] v1_out,
    input  logic [rs_pkg::XLEN-1:0] v2_out,
    output logic [rs_pkg::XLEN-1:0] result     // one cycle after start, held until the next
);
    import rs_pkg::*;

    logic [XLEN-1:0]      alu_out;  // combinational result of the current operands
    logic [SHAMT_LEN-1:0] shamt;    // shift distance
    logic                 less;     // signed compare for SLT

    assign shamt = v2_out[SHAMT_LEN-1:0];
    assign less  = $signed(v1_out) < $signed(v2_out);

    always_comb begin
        case (func_out)
            ALU_ADD: alu_out = v1_out + v2_out;
            ALU_SUB: alu_out = v1_out - v2_out;
            ALU_AND: alu_out = v1_out & v2_out;
            ALU_OR:  alu_out = v1_out | v2_out;
            ALU_XOR: alu_out = v1_out ^ v2_out;
            ALU_SLL: alu_out = v1_out << shamt;
            ALU_SRL: alu_out = v1_out >> shamt;  // zero fill from the top
            ALU_SLT: alu_out = {{(XLEN - 1){1'b0}}, less};
            default: alu_out = '0;
        endcase
    end

    // result register, it only moves on start so the broadcast cycle sees a stable value
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (start) begin
            result <= alu_out;
        end
    end

endmodule

// ==== rtl/issue_unit.sv ====
`timescale 1ns/1ns

module issue_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           insn_ready,  // station has an entry with both operands
    input  logic [rs_pkg::ROB_TAG_LEN-1:0] dst_tag,     // destination of the entry being selected
    output logic                           issue,
    output logic                           wakeup,      // broadcast valid, also the result valid
    output logic [rs_pkg::ROB_TAG_LEN-1:0] wakeup_tag
);
    import rs_pkg::*;

    // stage one lines up with the station's operand registers, stage two with the ALU result
    logic                   op_valid;
    logic [ROB_TAG_LEN-1:0] op_tag;

    // the ALU accepts a new operation every cycle, so nothing ever holds an issue back
    assign issue = insn_ready;

    // valid bits of both stages
    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
            wakeup   <= 1'b0;
        end else begin
            op_valid <= issue;     // high together with start
            wakeup   <= op_valid;  // high while result holds this operation's value
        end
    end

    // tag pipeline
    // a tag only moves with its valid bit, so an idle cycle leaves the last tag in place
    always_ff @(posedge clk) begin
        if (issue) begin
            op_tag <= dst_tag;
        end
        if (op_valid) begin
            wakeup_tag <= op_tag;
        end
    end

endmodule

// ==== rtl/reservation_station.sv ====
`timescale 1ns/1ns

module reservation_station (
    input  logic                           clk,
    input  logic                           reset,
    // dispatch side, one instruction per cycle with load
    input  logic                           load,
    input  rs_pkg::alu_func_t              func,
    input  logic [rs_pkg::ROB_TAG_LEN-1:0] t1,
    input  logic [rs_pkg::ROB_TAG_LEN-1:0] t2,
    input  logic [rs_pkg::ROB_TAG_LEN-1:0] dst,
    input  logic                           ready1,
    input  logic                           ready2,
    input  logic [rs_pkg::XLEN-1:0]        v1,
    input  logic [rs_pkg::XLEN-1:0]        v2,
    // issue decision and result broadcast
    input  logic                           issue,
    input  logic                           wakeup,
    input  logic [rs_pkg::ROB_TAG_LEN-1:0] wakeup_tag,
    input  logic [rs_pkg::XLEN-1:0]        wakeup_value,
    output logic                           insn_ready,     // some entry can issue this cycle
    output logic                           credit_return,  // one slot freed at the next edge
    output logic [rs_pkg::ROB_TAG_LEN-1:0] dst_tag,        // destination of the selected entry
    // operands to the ALU, registered one cycle after issue
    output logic                           start,
    output rs_pkg::alu_func_t              func_out,
    output logic [rs_pkg::XLEN-1:0]        v1_out,
    output logic [rs_pkg::XLEN-1:0]        v2_out
);
    import rs_pkg::*;

    rs_entry_t entries [NUM_ENTRIES];

    logic [ENTRY_WIDTH:0]   num_used;         // valid entries, can reach NUM_ENTRIES
    logic [ENTRY_WIDTH:0]   num_after_issue;  // occupancy once the issuing entry leaves
    logic [ENTRY_WIDTH-1:0] load_bday;        // age given to the incoming instruction
    logic [ENTRY_WIDTH-1:0] free_idx;         // lowest invalid slot
    logic [NUM_ENTRIES-1:0] wake1;            // source one of entry i matches the broadcast
    logic [NUM_ENTRIES-1:0] wake2;
    logic [NUM_ENTRIES-1:0] ready_flags;      // entry i has both operands this cycle
    logic [ENTRY_WIDTH-1:0] sel_idx;          // oldest ready entry
    logic [ENTRY_WIDTH-1:0] sel_bday;         // its age, younger entries move up behind it
    logic                   load_wake1;       // incoming source one is being broadcast now
    logic                   load_wake2;

    // occupancy count, ages run 0 .. num_used-1 so this is also the next free age
    always_comb begin
        num_used = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entries[i].valid) begin
                num_used = num_used + 1'b1;
            end
        end
    end

    // an issue in the same cycle shifts every younger age down by one, so the new entry
    // lands one place earlier
    assign num_after_issue = issue ? num_used - 1'b1 : num_used;
    assign load_bday       = num_after_issue[ENTRY_WIDTH-1:0];  // never 8 while a credit is held

    // lowest free slot, scanning down so the smallest index is the last one written
    always_comb begin
        free_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_idx = ENTRY_WIDTH'(i);
            end
        end
    end

    // wakeup match per entry
    // a source that is already ready holds a value, and its stale tag must not match
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            wake1[i] = wakeup && entries[i].valid && !entries[i].ready1
                       && (entries[i].t1 == wakeup_tag);
            wake2[i] = wakeup && entries[i].valid && !entries[i].ready2
                       && (entries[i].t2 == wakeup_tag);
            ready_flags[i] = entries[i].valid
                             && (entries[i].ready1 || wake1[i])
                             && (entries[i].ready2 || wake2[i]);
        end
    end

    // age-ordered select, ages are unique among valid entries so the smallest wins outright
    always_comb begin
        sel_idx  = '0;
        sel_bday = '1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (ready_flags[i] && (entries[i].bday <= sel_bday)) begin
                sel_idx  = ENTRY_WIDTH'(i);
                sel_bday = entries[i].bday;
            end
        end
    end

    assign insn_ready    = |ready_flags;
    assign dst_tag       = entries[sel_idx].dst;  // sampled by the issue unit only when issuing
    assign credit_return = issue;                 // slot is reusable from the next edge

    // incoming instruction sees the broadcast of the same cycle, else it would miss its tag
    assign load_wake1 = wakeup && !ready1 && (t1 == wakeup_tag);
    assign load_wake2 = wakeup && !ready2 && (t2 == wakeup_tag);

    // entry storage, only the valid bits need a defined value after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            // capture broadcast values into waiting sources
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (wake1[i]) begin
                    entries[i].ready1 <= 1'b1;
                    entries[i].v1     <= wakeup_value;
                end
                if (wake2[i]) begin
                    entries[i].ready2 <= 1'b1;
                    entries[i].v2     <= wakeup_value;
                end
            end

            if (issue) begin
                entries[sel_idx].valid <= 1'b0;  // the issued slot leaves at this edge
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if (entries[i].valid && (entries[i].bday > sel_bday)) begin
                        entries[i].bday <= entries[i].bday - 1'b1;  // close the gap
                    end
                end
            end

            // the free slot is invalid, so none of the updates above touch its fields
            if (load) begin
                entries[free_idx] <= '{
                    func:   func,
                    t1:     t1,
                    t2:     t2,
                    ready1: ready1 || load_wake1,
                    ready2: ready2 || load_wake2,
                    v1:     load_wake1 ? wakeup_value : v1,
                    v2:     load_wake2 ? wakeup_value : v2,
                    dst:    dst,
                    bday:   load_bday,
                    valid:  1'b1
                };
            end
        end
    end

    // operand registers, a source woken this cycle takes the broadcast value directly
    always_ff @(posedge clk) begin
        if (issue) begin
            func_out <= entries[sel_idx].func;
            v1_out   <= wake1[sel_idx] ? wakeup_value : entries[sel_idx].v1;
            v2_out   <= wake2[sel_idx] ? wakeup_value : entries[sel_idx].v2;
        end
    end

    // start marks the cycle in which the ALU operands are fresh
    always_ff @(posedge clk) begin
        if (reset) begin
            start <= 1'b0;
        end else begin
            start <= issue;
        end
    end

endmodule

// ==== rtl/rs_pkg.sv ====
package rs_pkg;

    // datapath and tag widths shared by the whole issue path
    localparam int XLEN        = 32;  // integer register width
    localparam int ROB_TAG_LEN = 5;   // physical tag width, enough for 32 in-flight results
    localparam int NUM_ENTRIES = 8;   // station depth, also the dispatcher's credit count
    localparam int ENTRY_WIDTH = 3;   // width of an entry index and of an age
    localparam int SHAMT_LEN   = 5;   // shifts use only the low bits of the second operand

    // ALU function select, carried with each instruction from dispatch to the ALU
    typedef enum logic [2:0] {
        ALU_ADD,  // v1 + v2
        ALU_SUB,  // v1 - v2
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,  // logical left shift of v1
        ALU_SRL,  // logical right shift of v1
        ALU_SLT   // signed less-than, gives 1 or 0
    } alu_func_t;

    // one reservation station slot
    // a source whose ready flag is clear holds a tag to wait on, and its value is filled in
    // by the broadcast that carries the same tag
    typedef struct packed {
        alu_func_t              func;
        logic [ROB_TAG_LEN-1:0] t1;      // tag of source one, only meaningful while not ready
        logic [ROB_TAG_LEN-1:0] t2;      // tag of source two
        logic                   ready1;
        logic                   ready2;
        logic [XLEN-1:0]        v1;      // operand value once ready1 is set
        logic [XLEN-1:0]        v2;
        logic [ROB_TAG_LEN-1:0] dst;     // tag broadcast with the result
        logic [ENTRY_WIDTH-1:0] bday;    // age, 0 is the oldest valid entry
        logic                   valid;
    } rs_entry_t;

endpackage
